// File: files.f
+incdir+source
source/rxLinkPkg.sv
source/symbolShifter.sv
source/pairTimer.sv
source/nibbleDecoder.sv
source/rxFrameFsm.sv
source/rxLinkTop.sv
test/rxLinkTb.sv

// File: Bender.yml
package:
  name: rx_link

sources:
  - include_dirs:
      - source
    files:
      - source/rxLinkPkg.sv
      - source/symbolShifter.sv
      - source/pairTimer.sv
      - source/nibbleDecoder.sv
      - source/rxFrameFsm.sv
      - source/rxLinkTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - test/rxLinkTb.sv

// File: test/rxLinkTb.sv
// self-checking testbench for rxLinkTop with one line bit per clk and all inputs changing on the falling edge
`timescale 1ns/1ps

module rxLinkTb;

    localparam logic [9:0] JK_PAIR   = 10'b11000_10001; // start delimiter
    localparam logic [9:0] TT_PAIR   = 10'b01101_01101; // end delimiter
    localparam logic [4:0] CODE_IDLE = 5'b11111;
    localparam int         EV_BYTE   = 0;
    localparam int         EV_DONE   = 1;
    localparam int         EV_ERR    = 2;
    localparam int         NEVER     = 32'h7fffffff;
    localparam int         WAIT_MAX  = 200; // cycles per wait

    logic       clk;
    logic       reset;
    logic       rx;
    logic       rxEn;
    logic       phaseLock;
    logic       frame;
    logic       rdy;
    logic       done;
    logic       errFlag;
    logic [7:0] dataOut;

    int         expKind[$];  // pending pulse kinds
    int         expData[$];  // byte for EV_BYTE
    int         expCycle[$]; // cycle the pulse must show up
    int         cycleCount;  // rising edges so far
    int         lastBitCycle;
    int         frameOnCycle;  // first cycle frame is high
    int         frameOffCycle; // first cycle frame is low again
    logic       inFrame;       // model thinks a frame is open
    logic       expFrame;

    rxLinkTop rxLinkTop_inst (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .rxEn      (rxEn),
        .phaseLock (phaseLock),
        .frame     (frame),
        .rdy       (rdy),
        .done      (done),
        .errFlag   (errFlag),
        .dataOut   (dataOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // 8 ns period
        end
    end

    // data nibble to its 5B code
    function automatic logic [4:0] codeForNibble(input logic [3:0] nib);
        logic [4:0] code;
        case (nib)
            4'h0: code = 5'b11110;
            4'h1: code = 5'b01001;
            4'h2: code = 5'b10100;
            4'h3: code = 5'b10101;
            4'h4: code = 5'b01010;
            4'h5: code = 5'b01011;
            4'h6: code = 5'b01110;
            4'h7: code = 5'b01111;
            4'h8: code = 5'b10010;
            4'h9: code = 5'b10011;
            4'hA: code = 5'b10110;
            4'hB: code = 5'b10111;
            4'hC: code = 5'b11010;
            4'hD: code = 5'b11011;
            4'hE: code = 5'b11100;
            default: code = 5'b11101;
        endcase
        return code;
    endfunction

    // reference encoder with the high nibble sent first
    function automatic logic [9:0] encodeByte(input logic [7:0] value);
        return {codeForNibble(value[7:4]), codeForNibble(value[3:0])};
    endfunction

    // inverse lookup giving {valid, nibble}
    function automatic logic [4:0] decodeCode(input logic [4:0] code);
        logic [4:0] res;
        int         n;
        res = 5'h00; // not found
        for (n = 0; n < 16; n++) begin
            if (codeForNibble(n[3:0]) == code) begin
                res = {1'b1, n[3:0]};
            end
        end
        return res;
    endfunction

    // expected {valid, byte} for one pair
    function automatic logic [8:0] decodePair(input logic [9:0] pairBits);
        logic [4:0] hiRes;
        logic [4:0] loRes;
        hiRes = decodeCode(pairBits[9:5]);
        loRes = decodeCode(pairBits[4:0]);
        return {hiRes[4] & loRes[4], hiRes[3:0], loRes[3:0]};
    endfunction

    task automatic failRun();
        $display("Simulation failed");
        $fatal(1, "run stopped at cycle %0d", cycleCount);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual=0x%0h expected=0x%0h at cycle %0d",
                     name, actual, expected, cycleCount);
            failRun();
        end
    endtask

    task automatic pushEvent(input int kind, input int data, input int due);
        expKind.push_back(kind);
        expData.push_back(data);
        expCycle.push_back(due);
    endtask

    // one bit per falling edge for the next rising edge
    task automatic sendBit(input logic bitValue);
        @(negedge clk);
        rx = bitValue;
        lastBitCycle = cycleCount + 1;
    endtask

    task automatic sendIdle(input int count);
        repeat (count) sendBit(1'b1);
    endtask

    // sends a pair msb first and feeds the frame model
    task automatic sendPair(input logic [9:0] pairBits);
        int         i;
        logic [8:0] dec;
        for (i = 9; i >= 0; i--) begin
            sendBit(pairBits[i]);
        end
        dec = decodePair(pairBits);
        if (rxEn && !inFrame) begin
            if (pairBits == JK_PAIR) begin
                inFrame       = 1'b1;
                frameOnCycle  = lastBitCycle + 2;
                frameOffCycle = NEVER;
            end
        end else if (rxEn) begin
            if (pairBits == TT_PAIR) begin // end wins over abort
                pushEvent(EV_DONE, 0, lastBitCycle + 2);
                inFrame       = 1'b0;
                frameOffCycle = lastBitCycle + 2;
            end else if (pairBits == JK_PAIR || pairBits[4:0] == CODE_IDLE || !dec[8]) begin
                pushEvent(EV_ERR, 0, lastBitCycle + 2);
                inFrame       = 1'b0;
                frameOffCycle = lastBitCycle + 2;
            end else begin
                pushEvent(EV_BYTE, dec[7:0], lastBitCycle + 2);
            end
        end
    endtask

    // JK plus random bytes without the end delimiter
    task automatic sendFrameHead(input int nBytes);
        int k;
        sendPair(JK_PAIR);
        for (k = 0; k < nBytes; k++) begin
            sendPair(encodeByte(8'($urandom_range(0, 255))));
        end
    endtask

    task automatic sendGoodFrame(input int nBytes);
        sendFrameHead(nBytes);
        sendPair(TT_PAIR);
    endtask

    // keeps the line idle until every expected pulse has been seen
    task automatic waitEventsDrained(input string what);
        int t;
        t = 0;
        while (expKind.size() != 0 && t < WAIT_MAX) begin
            sendBit(1'b1);
            t++;
        end
        if (expKind.size() != 0) begin
            $display("timeout while waiting for %s, a pending pulse never came", what);
            failRun();
        end
    endtask

    // outputs read 1 ns after each rising edge
    always @(posedge clk) begin : compareOutputs
        int kind;
        int data;
        int due;
        cycleCount++;
        #1;
        if (expKind.size() != 0 && cycleCount > expCycle[0]) begin
            $display("pulse due at cycle %0d did not arrive", expCycle[0]);
            failRun();
        end
        if (rdy || done || errFlag) begin
            if (expKind.size() == 0) begin
                $display("status pulse at cycle %0d with nothing expected", cycleCount);
                failRun();
            end else begin
                kind = expKind.pop_front();
                data = expData.pop_front();
                due  = expCycle.pop_front();
                checkValue("rdy", rdy, kind == EV_BYTE);
                checkValue("done", done, kind == EV_DONE);
                checkValue("errFlag", errFlag, kind == EV_ERR);
                checkValue("pulseCycle", cycleCount, due); // 2 cycles after last bit
                if (kind == EV_BYTE) begin
                    checkValue("dataOut", dataOut, data);
                end
            end
        end
        expFrame = (cycleCount >= frameOnCycle) && (cycleCount < frameOffCycle);
        checkValue("frame", frame, expFrame);
        checkValue("phaseLock", phaseLock, expFrame); // same as frame here
    end

    initial begin
        int         f;
        int         seedValue;
        logic [4:0] badCode;
        logic [7:0] goodByte;
        logic [9:0] cutPair;
        int         i;
        rx            = 1'b1; // idle line
        rxEn          = 1'b1;
        reset         = 1'b1;
        cycleCount    = 0;
        lastBitCycle  = 0;
        frameOnCycle  = NEVER;
        frameOffCycle = NEVER;
        inFrame       = 1'b0;
        expFrame      = 1'b0;
        seedValue     = $urandom(32'he3b4);
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // quiet idle line
        sendIdle(20);

        // good frames of random length
        for (f = 0; f < 4; f++) begin
            sendIdle(12);
            sendGoodFrame($urandom_range(1, 8));
            waitEventsDrained("good frame");
        end

        // invalid hi code aborts, then invalid lo code, each followed by a good frame
        for (i = 0; i < 2; i++) begin
            sendIdle(12);
            sendFrameHead(2);
            badCode = 5'($urandom_range(0, 31));
            while (decodeCode(badCode) != 5'h00 || badCode == CODE_IDLE) begin
                badCode = 5'($urandom_range(0, 31));
            end
            goodByte = 8'($urandom_range(0, 255));
            if (i == 0) begin
                sendPair({badCode, codeForNibble(goodByte[3:0])});
            end else begin
                sendPair({codeForNibble(goodByte[7:4]), badCode}); // not idle, so only codeBad
            end
            waitEventsDrained("invalid code abort");
            sendIdle(12);
            sendGoodFrame(3);
            waitEventsDrained("frame after invalid code");
        end

        // idle pair aborts
        sendIdle(12);
        sendFrameHead(1);
        sendPair({CODE_IDLE, CODE_IDLE});
        waitEventsDrained("idle pair abort");
        sendIdle(12);
        sendGoodFrame(2);
        waitEventsDrained("frame after idle pair");

        // disabled receiver ignores a whole frame
        sendIdle(12);
        rxEn = 1'b0;
        sendGoodFrame(4);
        sendIdle(12);
        rxEn = 1'b1;
        sendIdle(12);

        // rxEn dropped halfway through a pair
        sendFrameHead(2);
        cutPair = encodeByte(8'($urandom_range(0, 255)));
        for (i = 9; i >= 5; i--) begin
            sendBit(cutPair[i]);
        end
        rxEn          = 1'b0; // seen on the next rising edge
        inFrame       = 1'b0;
        frameOffCycle = cycleCount + 1;
        for (i = 4; i >= 0; i--) begin
            sendBit(cutPair[i]);
        end
        sendPair(TT_PAIR);
        sendIdle(12);
        rxEn = 1'b1;
        sendIdle(12);
        sendGoodFrame(2);
        waitEventsDrained("frame after rxEn drop");

        // repeated JK inside a frame
        sendIdle(12);
        sendFrameHead(2);
        sendPair(JK_PAIR);
        waitEventsDrained("repeated JK abort");
        sendIdle(12);
        sendGoodFrame($urandom_range(1, 8));
        waitEventsDrained("frame after repeated JK");
        sendIdle(20);

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: source/rxLinkTop.sv
// 4B/5B receiver, one line bit per clk with no phase recovery; outputs are unbuffered pulses
`timescale 1ns/1ps

module rxLinkTop (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    input  logic       rxEn,
    output logic       phaseLock,
    output logic       frame,
    output logic       rdy,
    output logic       done,
    output logic       errFlag,
    output logic [7:0] dataOut
);

    import rxLinkPkg::*;

    symPair_u pairWord;  // last ten line bits
    logic     jkSeen;    // start delimiter flag
    logic     ttSeen;    // end delimiter flag
    logic     iiSeen;    // idle code flag
    logic     timerLoad; // restart pair count
    logic     pairTick;  // full pair in window
    logic     codeBad;   // captured pair has a non-data code

    // line window and delimiters
    symbolShifter symbolShifter_inst (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .pairWord (pairWord),
        .jkSeen   (jkSeen),
        .ttSeen   (ttSeen),
        .iiSeen   (iiSeen)
    );

    // ten-bit pair framing
    pairTimer pairTimer_inst (
        .clk       (clk),
        .reset     (reset),
        .timerLoad (timerLoad),
        .pairTick  (pairTick)
    );

    nibbleDecoder nibbleDecoder_inst (
        .clk      (clk),
        .reset    (reset),
        .pairTick (pairTick),
        .pairWord (pairWord),
        .dataOut  (dataOut),
        .codeBad  (codeBad)
    );

    rxFrameFsm rxFrameFsm_inst (
        .clk       (clk),
        .reset     (reset),
        .rxEn      (rxEn),
        .jkSeen    (jkSeen),
        .ttSeen    (ttSeen),
        .iiSeen    (iiSeen),
        .pairTick  (pairTick),
        .codeBad   (codeBad),
        .timerLoad (timerLoad),
        .frame     (frame),
        .phaseLock (phaseLock),
        .rdy       (rdy),
        .done      (done),
        .errFlag   (errFlag)
    );

endmodule

// File: source/rxFrameFsm.sv
// frame FSM; rxEn low behaves as reset, no back-pressure so every byte is a single rdy pulse
`timescale 1ns/1ps

module rxFrameFsm (
    input  logic clk,
    input  logic reset,
    input  logic rxEn,
    input  logic jkSeen,
    input  logic ttSeen,
    input  logic iiSeen,
    input  logic pairTick,
    input  logic codeBad,
    output logic timerLoad,
    output logic frame,
    output logic phaseLock,
    output logic rdy,
    output logic done,
    output logic errFlag
);

    import rxLinkPkg::*;

    rxState_t state;     // current state
    rxState_t stateNext; // next state
    logic     pairEnd;   // TT pair, end of frame
    logic     pairErr;   // pair that aborts the frame
    logic     pairGood;  // data byte to hand out
    logic     frameOpen; // JK found while idle

    // pair verdict, only meaningful in stRecv
    // TT wins over any abort reason
    always_comb begin
        pairEnd  = ttSeen;
        pairErr  = !ttSeen && (jkSeen || iiSeen || codeBad);
        pairGood = !ttSeen && !jkSeen && !iiSeen && !codeBad;
    end

    assign frameOpen = (state == stIdle) && jkSeen;

    // timer starts on the JK flag and again on every accepted byte
    // both fall nine cycles before the next pair is complete
    assign timerLoad = rxEn && (frameOpen || ((state == stRecv) && pairGood));

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (jkSeen) begin
                    stateNext = stStart;
                end
            end
            stStart: begin
                if (pairTick) begin
                    stateNext = stRecv; // pair captured, verdict next cycle
                end
            end
            stRecv: begin
                if (pairGood) begin
                    stateNext = stStart; // back to back bytes
                end else begin
                    stateNext = stIdle; // end or abort
                end
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    // state register
    always_ff @(posedge clk) begin
        if (reset || !rxEn) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // status outputs
    // pulses default low every cycle
    always_ff @(posedge clk) begin
        if (reset || !rxEn) begin
            frame     <= 1'b0;
            phaseLock <= 1'b0;
            rdy       <= 1'b0;
            done      <= 1'b0;
            errFlag   <= 1'b0;
        end else begin
            rdy     <= 1'b0;
            done    <= 1'b0;
            errFlag <= 1'b0;
            if (frameOpen) begin
                frame     <= 1'b1; // frame starts the cycle after the JK flag
                phaseLock <= 1'b1; // locked for the whole frame
            end
            if (state == stRecv) begin
                if (pairEnd) begin
                    done      <= 1'b1;
                    frame     <= 1'b0;
                    phaseLock <= 1'b0;
                end else if (pairErr) begin
                    errFlag   <= 1'b1; // idle, repeated JK or bad code
                    frame     <= 1'b0;
                    phaseLock <= 1'b0;
                end else begin
                    rdy <= 1'b1; // dataOut already holds the byte
                end
            end
        end
    end

endmodule

// File: source/nibbleDecoder.sv
// 5B to 4B decode of both halves; dataOut and codeBad change only on pairTick
`timescale 1ns/1ps

module nibbleDecoder (
    input  logic                clk,
    input  logic                reset,
    input  logic                pairTick,
    input  rxLinkPkg::symPair_u pairWord,
    output logic [7:0]          dataOut,
    output logic                codeBad
);

    import rxLinkPkg::*;

    logic [3:0] hiNib; // upper data nibble
    logic [3:0] loNib; // lower data nibble
    logic       hiBad; // hi code not a data code
    logic       loBad; // lo code not a data code

    // returns {invalid, nibble}
    function automatic logic [4:0] decode5b(input code5_t code);
        logic [4:0] res;
        case (code)
            5'b11110: res = 5'h00;
            5'b01001: res = 5'h01;
            5'b10100: res = 5'h02;
            5'b10101: res = 5'h03;
            5'b01010: res = 5'h04;
            5'b01011: res = 5'h05;
            5'b01110: res = 5'h06;
            5'b01111: res = 5'h07;
            5'b10010: res = 5'h08;
            5'b10011: res = 5'h09;
            5'b10110: res = 5'h0A;
            5'b10111: res = 5'h0B;
            5'b11010: res = 5'h0C;
            5'b11011: res = 5'h0D;
            5'b11100: res = 5'h0E;
            5'b11101: res = 5'h0F;
            default:  res = 5'h10; // control or unused code
        endcase
        return res;
    endfunction

    // same table on both halves
    always_comb begin
        {hiBad, hiNib} = decode5b(pairWord.half.hi);
        {loBad, loNib} = decode5b(pairWord.half.lo);
    end

    // byte holds until the next pair
    always_ff @(posedge clk) begin
        if (pairTick) begin
            dataOut <= {hiNib, loNib}; // first code is the high nibble
        end
    end

    // bad flag for the captured pair
    always_ff @(posedge clk) begin
        if (reset) begin
            codeBad <= 1'b0;
        end else if (pairTick) begin
            codeBad <= hiBad | loBad;
        end
    end

endmodule

// File: source/pairTimer.sv
// one pairTick per load, nine cycles after the load cycle; a new load restarts the count
`timescale 1ns/1ps
`include "rxLink_config.svh"

module pairTimer (
    input  logic clk,
    input  logic reset,
    input  logic timerLoad,
    output logic pairTick
);

    logic [3:0] count; // remaining cycles to the tick
    logic       armed; // counting, tick still pending

    // load cycle itself stands for the reload value
    // so the register starts one below it
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            armed <= 1'b0; // parked, no tick
        end else if (timerLoad) begin
            count <= 4'(`RX_PAIR_RELOAD - 1);
            armed <= 1'b1;
        end else if (armed) begin
            if (count == 4'd0) begin
                armed <= 1'b0; // tick done, park at zero
            end else begin
                count <= count - 4'd1;
            end
        end
    end

    // high while the full pair sits in the shifter
    assign pairTick = armed && (count == 4'd0);

endmodule

// File: source/symbolShifter.sv
// sliding 10-bit window of the line; delimiter flags lag the window by one cycle
`timescale 1ns/1ps
`include "rxLink_config.svh"

module symbolShifter (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx,
    output rxLinkPkg::symPair_u pairWord,
    output logic                jkSeen,
    output logic                ttSeen,
    output logic                iiSeen
);

    import rxLinkPkg::*;

    logic isJk; // window holds J then K
    logic isTt; // window holds T then T
    logic isIi; // newest code is idle

    // newest bit enters at the lsb
    // so the first bit of a pair ends up as the msb of hi
    always_ff @(posedge clk) begin
        if (reset) begin
            pairWord.raw <= '0;
        end else begin
            pairWord.raw <= {pairWord.raw[`RX_PAIR_BITS-2:0], rx};
        end
    end

    // compare against the current window
    always_comb begin
        isJk = (pairWord.half.hi == CODE_J) && (pairWord.half.lo == CODE_K);
        isTt = (pairWord.half.hi == CODE_T) && (pairWord.half.lo == CODE_T);
        isIi = (pairWord.half.lo == CODE_I); // only the lo half matters
    end

    // registered flags, one cycle behind pairWord
    // lines up with the decoder output for the same pair
    always_ff @(posedge clk) begin
        if (reset) begin
            jkSeen <= 1'b0;
            ttSeen <= 1'b0;
            iiSeen <= 1'b1; // line idles high
        end else begin
            jkSeen <= isJk;
            ttSeen <= isTt;
            iiSeen <= isIi;
        end
    end

endmodule

// File: source/rxLinkPkg.sv
// shared receiver types; code constants follow the standard 4B/5B table and are not configurable
`include "rxLink_config.svh"

package rxLinkPkg;

    // one 5B line code
    typedef logic [`RX_CODE_BITS-1:0] code5_t;

    // frame FSM states
    typedef enum logic [1:0] {
        stIdle  = 2'd0, // waiting for JK
        stStart = 2'd1, // counting out the next pair
        stRecv  = 2'd2  // pair decoded, judge it
    } rxState_t;

    // ten line bits seen two ways
    // raw for the shift and delimiter compare
    // half for the per-code decode, hi arrived first
    typedef union packed {
        logic [`RX_PAIR_BITS-1:0] raw;
        struct packed {
            code5_t hi; // first code on the line
            code5_t lo; // second code on the line
        } half;
    } symPair_u;

    // control codes
    localparam code5_t CODE_J = 5'b11000; // start delimiter, first half
    localparam code5_t CODE_K = 5'b10001; // start delimiter, second half
    localparam code5_t CODE_T = 5'b01101; // end delimiter, both halves
    localparam code5_t CODE_I = 5'b11111; // idle line

endpackage

// File: source/rxLink_config.svh
// fixed 4B/5B line code widths and pair timing; one line bit per clk, no other values supported
`ifndef RXLINK_CONFIG_SVH
`define RXLINK_CONFIG_SVH

// width of one 5B line code
`define RX_CODE_BITS 5

// two codes per received byte
`define RX_PAIR_BITS 10

// pair timer reload
// the load cycle counts as the first of ten, so the tick lands on every tenth cycle
`define RX_PAIR_RELOAD 9

`endif
